/* flist.f */
+incdir+.
spi_avmm_pkg.sv
spi_cmd_master.sv
spi_avmm_slave.sv
app_avmm_csr.sv
spi_avmm_top.sv
tb_spi_avmm_top.sv

/* Bender.yml */
package:
  name: spi_avmm

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spi_avmm_pkg.sv
      - spi_cmd_master.sv
      - spi_avmm_slave.sv
      - app_avmm_csr.sv
      - spi_avmm_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spi_avmm_top.sv

/* tb_spi_avmm_top.sv */
// Testbench for the SPI to Avalon-MM configuration path
// Table-driven commands checked against a local model of the register file
`timescale 1ns/1ps
`include "spi_avmm_defs.svh"

module tb_spi_avmm_top;
    import spi_avmm_pkg::*;

    localparam int TBL_LEN     = 34;
    localparam int CYCLE_LIMIT = TBL_LEN * 600 + 100;
    localparam int CTRL        = `CSR_CTRL_NUM;
    localparam int STAT        = `CSR_STAT_NUM;

    logic                  dut_slave1;
    logic                  rst_n;
    logic                  cmd_valid;
    spi_cmd_t              cmd;
    logic                  busy;
    logic                  cmd_done;
    csr_word_t             rdata;
    csr_word_t [STAT-1:0]  user_status;
    csr_word_t [CTRL-1:0]  user_csr;

    // Command table
    string     tname  [TBL_LEN];
    spi_cmd_t  tcmd   [TBL_LEN];
    csr_word_t texp   [TBL_LEN];
    bit        tmodel [TBL_LEN];
    int        tbl_n;

    // Reference copy of the control registers
    csr_word_t model [CTRL];

    logic [31:0] lfsr;
    int          err_cnt   = 0;
    int          done_cnt  = 0;
    int          cycle_cnt = 0;

    spi_avmm_top UUT (
        .dut_slave1  (dut_slave1),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .busy        (busy),
        .cmd_done    (cmd_done),
        .rdata       (rdata),
        .user_status (user_status),
        .user_csr    (user_csr)
    );

    // 4 ns clock
    initial dut_slave1 = 1'b0;
    always #2 dut_slave1 = ~dut_slave1;

    // ------------------------------------------------------------------
    // Monitors
    // ------------------------------------------------------------------

    // Every done pulse counted, compared per command
    always @(posedge dut_slave1) begin
        if (rst_n && cmd_done) begin
            done_cnt++;
        end
    end

    // Hang guard
    always @(posedge dut_slave1) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped finishing commands", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_word(output csr_word_t w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            w    = {w[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    task automatic add_entry(input string name, input logic wr, input byte_en_t be,
                             input csr_addr_t addr, input csr_word_t wdata,
                             input csr_word_t exp, input bit use_model);
        tname[tbl_n]  = name;
        tcmd[tbl_n]   = '{write: wr, byte_en: be, addr: addr, wdata: wdata};
        texp[tbl_n]   = exp;
        tmodel[tbl_n] = use_model;
        tbl_n++;
    endtask

    task automatic report_mismatch(input string name, input csr_word_t exp,
                                   input csr_word_t act);
        err_cnt++;
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
    endtask

    // Byte merge into the model, only the control range is writable
    task automatic model_write(input spi_cmd_t c);
        if (c.addr < CTRL) begin
            for (int b = 0; b < 4; b++) begin
                if (c.byte_en[b]) begin
                    model[c.addr][8*b +: 8] = c.wdata[8*b +: 8];
                end
            end
        end
    endtask

    task automatic build_table();
        csr_word_t w;
        tbl_n = 0;
        // Control registers come out of reset as zero
        for (int i = 0; i < CTRL; i++) begin
            add_entry($sformatf("rst_rd_ctrl%0d", i), 1'b0, 4'hf, i, '0, '0, 1'b0);
        end
        // Full word writes and read-back
        draw_word(w);
        add_entry("wr_full_ctrl2", 1'b1, 4'hf, 16'd2, w, '0, 1'b0);
        add_entry("rd_full_ctrl2", 1'b0, 4'hf, 16'd2, '0, '0, 1'b1);
        draw_word(w);
        add_entry("wr_full_ctrl5", 1'b1, 4'hf, 16'd5, w, '0, 1'b0);
        add_entry("rd_full_ctrl5", 1'b0, 4'hf, 16'd5, '0, '0, 1'b1);
        // Partial writes over the full ones
        draw_word(w);
        add_entry("wr_part_ctrl2", 1'b1, 4'b0101, 16'd2, w, '0, 1'b0);
        add_entry("rd_part_ctrl2", 1'b0, 4'hf, 16'd2, '0, '0, 1'b1);
        draw_word(w);
        add_entry("wr_part_ctrl5", 1'b1, 4'b1000, 16'd5, w, '0, 1'b0);
        add_entry("rd_part_ctrl5", 1'b0, 4'hf, 16'd5, '0, '0, 1'b1);
        // Status window
        for (int i = 0; i < STAT; i++) begin
            add_entry($sformatf("rd_stat%0d", i), 1'b0, 4'hf,
                      csr_addr_t'(`CSR_STAT_BASE + i), '0, user_status[i], 1'b0);
        end
        draw_word(w);
        add_entry("wr_stat1", 1'b1, 4'hf, csr_addr_t'(`CSR_STAT_BASE + 1), w, '0, 1'b0);
        add_entry("rd_stat1", 1'b0, 4'hf, csr_addr_t'(`CSR_STAT_BASE + 1), '0,
                  user_status[1], 1'b0);
        // Unmapped, including the words just past each range
        add_entry("rd_unmap_0040", 1'b0, 4'hf, 16'h0040, '0, `CSR_UNMAPPED_DATA, 1'b0);
        add_entry("rd_unmap_0104", 1'b0, 4'hf, 16'h0104, '0, `CSR_UNMAPPED_DATA, 1'b0);
        draw_word(w);
        add_entry("wr_unmap_0008", 1'b1, 4'hf, 16'h0008, w, '0, 1'b0);
        draw_word(w);
        add_entry("wr_unmap_0200", 1'b1, 4'hf, 16'h0200, w, '0, 1'b0);
        // Nothing moved in the control range
        for (int i = 0; i < CTRL; i++) begin
            add_entry($sformatf("rd_back_ctrl%0d", i), 1'b0, 4'hf, i, '0, '0, 1'b1);
        end
    endtask

    // One command, launched 1 ns after an edge, finished on cmd_done
    task automatic run_entry(input int idx);
        csr_word_t exp;
        int        busy_low;
        busy_low  = 0;
        cmd       = tcmd[idx];
        cmd_valid = 1'b1;
        @(posedge dut_slave1);
        #1;
        cmd_valid = 1'b0;
        while (!cmd_done) begin
            if (!busy) begin
                busy_low++;
            end
            @(posedge dut_slave1);
            #1;
        end
        if (busy_low != 0) begin
            err_cnt++;
            $display("busy dropped for %0d cycles before cmd_done in %s",
                     busy_low, tname[idx]);
        end
        if (busy !== 1'b0) begin
            report_mismatch({tname[idx], " busy at done"}, 32'd0, busy);
        end
        if (!tcmd[idx].write) begin
            exp = tmodel[idx] ? model[tcmd[idx].addr] : texp[idx];
            if (rdata !== exp) begin
                report_mismatch(tname[idx], exp, rdata);
            end
        end else begin
            model_write(tcmd[idx]);
        end
        // Quiet cycles catch a second done pulse
        repeat (2) begin
            @(posedge dut_slave1);
            #1;
        end
        if (done_cnt != idx + 1) begin
            err_cnt++;
            $display("cmd_done pulsed %0d times over %0d commands, at %s",
                     done_cnt, idx + 1, tname[idx]);
        end
        for (int k = 0; k < CTRL; k++) begin
            if (user_csr[k] !== model[k]) begin
                report_mismatch($sformatf("%s user_csr[%0d]", tname[idx], k),
                                model[k], user_csr[k]);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        lfsr      = 32'hac59;
        for (int i = 0; i < STAT; i++) begin
            draw_word(user_status[i]);
        end
        for (int i = 0; i < CTRL; i++) begin
            model[i] = '0;
        end
        build_table();
        if (tbl_n != TBL_LEN) begin
            err_cnt++;
            $display("Command table holds %0d entries instead of %0d", tbl_n, TBL_LEN);
        end

        // Reset for two cycles
        repeat (2) @(posedge dut_slave1);
        #1;
        rst_n = 1'b1;

        // Idle outputs after reset
        if (busy !== 1'b0) begin
            report_mismatch("reset busy", 32'd0, busy);
        end
        if (cmd_done !== 1'b0) begin
            report_mismatch("reset cmd_done", 32'd0, cmd_done);
        end
        for (int k = 0; k < CTRL; k++) begin
            if (user_csr[k] !== '0) begin
                report_mismatch($sformatf("reset user_csr[%0d]", k), '0, user_csr[k]);
            end
        end

        for (int i = 0; i < tbl_n; i++) begin
            run_entry(i);
        end

        $display("%0d errors, %0d commands, %0d cmd_done pulses", err_cnt, tbl_n, done_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* spi_avmm_top.sv */
// SPI to Avalon-MM configuration path top level
// Command master, SPI slave and application registers
`timescale 1ns/1ps
`include "spi_avmm_defs.svh"

module spi_avmm_top (
    input  logic                                        dut_slave1,
    input  logic                                        rst_n,
    input  logic                                        cmd_valid,
    input  spi_avmm_pkg::spi_cmd_t                      cmd,
    output logic                                        busy,
    output logic                                        cmd_done,
    output spi_avmm_pkg::csr_word_t                     rdata,
    input  spi_avmm_pkg::csr_word_t [`CSR_STAT_NUM-1:0] user_status,
    output spi_avmm_pkg::csr_word_t [`CSR_CTRL_NUM-1:0] user_csr
);
    import spi_avmm_pkg::*;

    // SPI wires between master and slave
    spi_lines_t spi;
    logic       miso;

    // Avalon-MM between slave and registers
    avmm_req_t  avmm_req;
    avmm_rsp_t  avmm_rsp;

    // Host side SPI master
    spi_cmd_master u_mspi (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .busy       (busy),
        .cmd_done   (cmd_done),
        .rdata      (rdata),
        .spi        (spi),
        .miso       (miso)
    );

    // Frame decoder and bus master
    spi_avmm_slave u_sspi (
        .dut_slave1 (dut_slave1),
        .rst_n      (rst_n),
        .spi        (spi),
        .miso       (miso),
        .avmm_req   (avmm_req),
        .avmm_rsp   (avmm_rsp)
    );

    app_avmm_csr #(
        .CTRL_NUM (`CSR_CTRL_NUM),
        .STAT_NUM (`CSR_STAT_NUM)
    ) app_reg (
        .dut_slave1  (dut_slave1),
        .rst_n       (rst_n),
        .avmm_req    (avmm_req),
        .avmm_rsp    (avmm_rsp),
        .user_status (user_status),
        .user_csr    (user_csr)
    );

endmodule

/* app_avmm_csr.sv */
// Application register block on Avalon-MM
// Byte-enabled control registers, read-only status registers, fixed unmapped value
`timescale 1ns/1ps
`include "spi_avmm_defs.svh"

module app_avmm_csr #(
    parameter int CTRL_NUM = `CSR_CTRL_NUM,
    parameter int STAT_NUM = `CSR_STAT_NUM
) (
    input  logic                                   dut_slave1,
    input  logic                                   rst_n,
    input  spi_avmm_pkg::avmm_req_t                avmm_req,
    output spi_avmm_pkg::avmm_rsp_t                avmm_rsp,
    input  spi_avmm_pkg::csr_word_t [STAT_NUM-1:0] user_status,
    output spi_avmm_pkg::csr_word_t [CTRL_NUM-1:0] user_csr
);
    import spi_avmm_pkg::*;

    localparam int CTRL_IW = (CTRL_NUM > 1) ? $clog2(CTRL_NUM) : 1;
    localparam int STAT_IW = (STAT_NUM > 1) ? $clog2(STAT_NUM) : 1;
    localparam int BYTES   = $bits(byte_en_t);

    csr_word_t [CTRL_NUM-1:0] ctrl_q;
    csr_addr_t                stat_off;
    logic                     ctrl_hit;
    logic                     stat_hit;
    logic [CTRL_IW-1:0]       ctrl_idx;
    logic [STAT_IW-1:0]       stat_idx;
    logic                     rvalid_q;
    csr_word_t                rdata_q;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    always_comb begin
        // Offset into the status window
        stat_off = avmm_req.address - csr_addr_t'(`CSR_STAT_BASE);
        ctrl_hit = (avmm_req.address < CTRL_NUM);
        stat_hit = (avmm_req.address >= `CSR_STAT_BASE) && (stat_off < STAT_NUM);
        ctrl_idx = avmm_req.address[CTRL_IW-1:0];
        stat_idx = stat_off[STAT_IW-1:0];
    end

    // ------------------------------------------------------------------
    // Control registers
    // ------------------------------------------------------------------
    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= avmm_req.read;
            // Status and unmapped writes are dropped
            if (avmm_req.write && ctrl_hit) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (avmm_req.byteenable[b]) begin
                        ctrl_q[ctrl_idx][8*b +: 8] <= avmm_req.writedata[8*b +: 8];
                    end
                end
            end
        end
    end

    // Read mux, registered
    always_ff @(posedge dut_slave1) begin
        if (avmm_req.read) begin
            if (ctrl_hit) begin
                rdata_q <= ctrl_q[ctrl_idx];
            end else if (stat_hit) begin
                rdata_q <= user_status[stat_idx];
            end else begin
                rdata_q <= `CSR_UNMAPPED_DATA;
            end
        end
    end

    assign user_csr = ctrl_q;
    assign avmm_rsp = '{readdatavalid: rvalid_q, readdata: rdata_q};

endmodule

/* spi_avmm_slave.sv */
// SPI slave acting as Avalon-MM master
// Decodes SPI frames into register reads and writes, returns read data on miso
`timescale 1ns/1ps
`include "spi_avmm_defs.svh"

module spi_avmm_slave (
    input  logic                     dut_slave1,
    input  logic                     rst_n,
    input  spi_avmm_pkg::spi_lines_t spi,
    output logic                     miso,
    output spi_avmm_pkg::avmm_req_t  avmm_req,
    input  spi_avmm_pkg::avmm_rsp_t  avmm_rsp
);
    import spi_avmm_pkg::*;

    slv_state_t state;
    logic [1:0] sclk_sync;
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sclk_prev;
    logic       cs_prev;
    logic       mosi_s;
    logic       sclk_rise;
    logic       sclk_fall;
    logic       cs_rise;
    logic [4:0] bit_cnt;
    logic [4:0] phase_last;
    logic       phase_end;
    logic       op_write;
    byte_en_t   op_be;
    csr_addr_t  addr_q;
    csr_word_t  in_shreg;
    csr_word_t  tx_shreg;
    logic       read_q;
    logic       write_q;

    // Edge detect on synchronized lines
    assign mosi_s    = mosi_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign cs_rise   = cs_sync[1] & ~cs_prev;

    // Index of the last bit in each phase
    always_comb begin
        case (state)
            OPCODE:  phase_last = 5'(`SPI_OP_BITS - 1);
            ADDR:    phase_last = 5'(`SPI_ADDR_BITS - 1);
            TURN:    phase_last = 5'(`SPI_TURN_BITS - 1);
            DATA:    phase_last = 5'(`SPI_DATA_BITS - 1);
            default: phase_last = 5'd0;
        endcase
    end

    assign phase_end = !cs_sync[1] && sclk_rise && (bit_cnt == phase_last);

    // Read data goes out MSB first
    assign miso = tx_shreg[31];

    assign avmm_req = '{read: read_q, write: write_q, address: addr_q,
                        byteenable: op_be, writedata: in_shreg};

    // ------------------------------------------------------------------
    // Synchronizers and frame FSM
    // ------------------------------------------------------------------
    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            state     <= OPCODE;
            bit_cnt   <= '0;
            sclk_sync <= 2'b00;
            cs_sync   <= 2'b11;
            sclk_prev <= 1'b0;
            cs_prev   <= 1'b1;
            op_write  <= 1'b0;
            read_q    <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi.sclk};
            cs_sync   <= {cs_sync[0], spi.cs_n};
            sclk_prev <= sclk_sync[1];
            cs_prev   <= cs_sync[1];
            read_q    <= 1'b0;
            write_q   <= 1'b0;
            if (cs_sync[1]) begin
                // Deselected, a complete write frame commits now
                state   <= OPCODE;
                bit_cnt <= '0;
                write_q <= cs_rise && (state == COMMIT) && op_write;
            end else if (sclk_rise) begin
                if (phase_end) begin
                    bit_cnt <= '0;
                    case (state)
                        OPCODE: begin
                            op_write <= in_shreg[6];
                            state    <= ADDR;
                        end
                        ADDR: begin
                            // Read launched right after the last address bit
                            read_q <= !op_write;
                            state  <= TURN;
                        end
                        TURN:    state <= DATA;
                        default: state <= COMMIT;
                    endcase
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Data path
    // ------------------------------------------------------------------
    always_ff @(posedge dut_slave1) begin
        mosi_sync <= {mosi_sync[0], spi.mosi};
        if (!cs_sync[1] && sclk_rise) begin
            in_shreg <= {in_shreg[30:0], mosi_s};
        end
        if (phase_end && state == OPCODE) begin
            op_be <= {in_shreg[2:0], mosi_s};
        end
        if (phase_end && state == ADDR) begin
            addr_q <= {in_shreg[14:0], mosi_s};
        end
        // Load during turnaround, shift after each sampled data bit
        if (avmm_rsp.readdatavalid) begin
            tx_shreg <= avmm_rsp.readdata;
        end else if (state == DATA && sclk_fall && bit_cnt != '0) begin
            tx_shreg <= {tx_shreg[30:0], 1'b0};
        end
    end

    a_rd_wr_exclusive: assert property (
        @(posedge dut_slave1) disable iff (!rst_n) !(avmm_req.read && avmm_req.write)
    );

    // Response has to land in the turnaround window
    a_rsp_before_data: assert property (
        @(posedge dut_slave1) disable iff (!rst_n)
        avmm_req.read |=> avmm_rsp.readdatavalid && (state == TURN)
    ) else $error("readdatavalid missed the turnaround window");

endmodule

/* spi_cmd_master.sv */
// SPI command master
// Turns one host command into one 64 bit SPI frame and returns read data
`timescale 1ns/1ps
`include "spi_avmm_defs.svh"

module spi_cmd_master (
    input  logic                     dut_slave1,
    input  logic                     rst_n,
    input  logic                     cmd_valid,
    input  spi_avmm_pkg::spi_cmd_t   cmd,
    output logic                     busy,
    output logic                     cmd_done,
    output spi_avmm_pkg::csr_word_t  rdata,
    output spi_avmm_pkg::spi_lines_t spi,
    input  logic                     miso
);
    import spi_avmm_pkg::*;

    localparam int FRAME = `SPI_FRAME_BITS;
    localparam int DIV_W = (`SPI_CLK_DIV > 1) ? $clog2(`SPI_CLK_DIV) : 1;
    localparam int BIT_W = $clog2(FRAME);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(FRAME - 1);

    mst_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic             sclk_q;
    logic             cs_n_q;
    logic             is_write;
    logic [FRAME-1:0] frame;
    logic [FRAME-1:0] tx_shreg;
    csr_word_t        rx_shreg;
    logic             half_tick;
    logic             finish_done;

    // Opcode, address, turnaround, data
    assign frame = {cmd.write, 3'b000, cmd.byte_en, cmd.addr,
                    {`SPI_TURN_BITS{1'b0}}, cmd.wdata};

    // End of an SCLK half period
    assign half_tick   = (div_cnt == DIV_LAST);
    // Last cycle of the trailing gap
    assign finish_done = (state == FINISH) && (div_cnt == DIV_LAST);

    // mosi is parked low while deselected
    assign spi = '{sclk: sclk_q, cs_n: cs_n_q, mosi: tx_shreg[FRAME-1] & ~cs_n_q};

    // ------------------------------------------------------------------
    // Sequencing FSM and SCLK generation
    // ------------------------------------------------------------------
    always_ff @(posedge dut_slave1) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
            busy     <= 1'b0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                IDLE: begin
                    // Commands while busy never reach here and are dropped
                    if (cmd_valid) begin
                        state   <= SHIFT;
                        cs_n_q  <= 1'b0;
                        busy    <= 1'b1;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                SHIFT: begin
                    div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                    if (half_tick) begin
                        sclk_q <= ~sclk_q;
                        // Falling edge closes one bit
                        if (sclk_q) begin
                            if (bit_cnt == BIT_LAST) begin
                                state  <= FINISH;
                                cs_n_q <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                end
                FINISH: begin
                    // Gap lets the slave see deselect and commit a write
                    div_cnt <= div_cnt + 1'b1;
                    if (finish_done) begin
                        state    <= IDLE;
                        div_cnt  <= '0;
                        busy     <= 1'b0;
                        cmd_done <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Frame shift registers
    // ------------------------------------------------------------------
    always_ff @(posedge dut_slave1) begin
        if (state == IDLE && cmd_valid) begin
            tx_shreg <= frame;
            is_write <= cmd.write;
        end else if (state == SHIFT && half_tick) begin
            if (!sclk_q) begin
                // Rising edge, sample slave data
                rx_shreg <= {rx_shreg[30:0], miso};
            end else begin
                // Falling edge, present next bit
                tx_shreg <= {tx_shreg[FRAME-2:0], 1'b0};
            end
        end
        // Last 32 sampled bits are the data field
        if (finish_done && !is_write) begin
            rdata <= rx_shreg;
        end
    end

    // Host must wait for cmd_done
    a_no_cmd_while_busy: assert property (
        @(posedge dut_slave1) disable iff (!rst_n) cmd_valid |-> !busy
    ) else $error("cmd_valid while busy, command dropped");

    // Chip select held through the whole frame
    a_cs_low_in_shift: assert property (
        @(posedge dut_slave1) disable iff (!rst_n) (state == SHIFT) |-> !spi.cs_n
    );

endmodule

/* spi_avmm_pkg.sv */
// SPI to Avalon-MM configuration path
// Shared data types, bus structs and FSM state encodings

package spi_avmm_pkg;

    // ------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------

    // Register data word
    typedef logic [31:0] csr_word_t;

    // Word address
    typedef logic [15:0] csr_addr_t;

    // One enable per data byte
    typedef logic [3:0] byte_en_t;

    // ------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------

    // Host command, one per SPI frame
    typedef struct packed {
        logic      write;
        byte_en_t  byte_en;
        csr_addr_t addr;
        csr_word_t wdata;
    } spi_cmd_t;

    // Master driven SPI lines
    typedef struct packed {
        logic sclk;
        logic cs_n;
        logic mosi;
    } spi_lines_t;

    // Avalon-MM request, read and write are single cycle strobes
    typedef struct packed {
        logic      read;
        logic      write;
        csr_addr_t address;
        byte_en_t  byteenable;
        csr_word_t writedata;
    } avmm_req_t;

    // Avalon-MM read response
    typedef struct packed {
        logic      readdatavalid;
        csr_word_t readdata;
    } avmm_rsp_t;

    // FSM states
    typedef enum logic [1:0] {IDLE, SHIFT, FINISH} mst_state_t;
    typedef enum logic [2:0] {OPCODE, ADDR, TURN, DATA, COMMIT} slv_state_t;

endpackage

/* spi_avmm_defs.svh */
// SPI to Avalon-MM configuration path
// Frame layout, SCLK divider and register map constants

`ifndef SPI_AVMM_DEFS_SVH
`define SPI_AVMM_DEFS_SVH

// ----------------------------------------------------------------------
// SPI clocking
// ----------------------------------------------------------------------

// dut_slave1 cycles per SCLK half period
`define SPI_CLK_DIV 4

// ----------------------------------------------------------------------
// Frame layout, MSB first
// ----------------------------------------------------------------------

// Whole frame while cs_n is low
`define SPI_FRAME_BITS 64

// Opcode field, bit 7 write, bits 3..0 byte enable
`define SPI_OP_BITS 8

// Word address field
`define SPI_ADDR_BITS 16

// Turnaround between address and data
`define SPI_TURN_BITS 8

// Data field, from mosi on writes, from miso on reads
`define SPI_DATA_BITS 32

// ----------------------------------------------------------------------
// Application register map
// ----------------------------------------------------------------------

`define CSR_CTRL_NUM 8
`define CSR_STAT_NUM 4
// First status register word address
`define CSR_STAT_BASE 16'h0100
// Returned on reads outside both ranges
`define CSR_UNMAPPED_DATA 32'hdead_beef

`endif
